//--- axi_cdc_pkg.sv
package axi_cdc_pkg;

    // Bus field widths
    localparam int id_w    = 2;
    localparam int addr_w  = 32;
    localparam int len_w   = 8;
    localparam int burst_w = 2;
    localparam int data_w  = 32;
    localparam int strb_w  = 4;
    localparam int resp_w  = 2;

    // Address channel payload
    // {id, addr, len, burst}
    localparam int aw_pkt_w = id_w + addr_w + len_w + burst_w;

    // Write data payload
    // {data, strb, last}
    localparam int wd_pkt_w = data_w + strb_w + 1;

    // Read data payload
    // {id, data, resp, last}
    localparam int rd_pkt_w = id_w + data_w + resp_w + 1;

    // Write response payload
    // {id, resp}
    localparam int wb_pkt_w = id_w + resp_w;

    // Channel FIFO size is a power of two
    localparam int fifo_depth = 16;
    localparam int fifo_aw    = $clog2(fifo_depth);

    // Free entries left when almost_full rises
    // Covers the registered flag and the ready already granted
    localparam int afull_margin = 3;

    // Read-side output register state
    typedef enum logic {
        ost_empty,
        ost_loaded
    } out_state_t;

endpackage

//--- cdc_async_fifo.sv
module cdc_async_fifo #(
    parameter int width = 8
) (
    input  logic             wr_clk,
    input  logic             wr_rstn,
    input  logic             wr_en,
    input  logic [width-1:0] wr_data,
    output logic             full,
    output logic             almost_full,
    input  logic             rd_clk,
    input  logic             rd_rstn,
    input  logic             rd_en,
    output logic [width-1:0] rd_data,
    output logic             empty
);
    import axi_cdc_pkg::*;

    logic [width-1:0] mem [fifo_depth];

    // Write domain
    logic [fifo_aw:0] wr_bin;
    logic [fifo_aw:0] wr_gray;
    logic [fifo_aw:0] wr_bin_next;
    logic [fifo_aw:0] wr_gray_next;
    logic [fifo_aw:0] rd_gray_meta;
    logic [fifo_aw:0] rd_gray_sync;
    logic [fifo_aw:0] rd_bin_sync;
    logic [fifo_aw:0] wr_level_next;
    logic             wr_push;

    // Read domain
    logic [fifo_aw:0] rd_bin;
    logic [fifo_aw:0] rd_gray;
    logic [fifo_aw:0] rd_bin_next;
    logic [fifo_aw:0] rd_gray_next;
    logic [fifo_aw:0] wr_gray_meta;
    logic [fifo_aw:0] wr_gray_sync;
    logic             rd_pop;

    function automatic logic [fifo_aw:0] gray2bin(input logic [fifo_aw:0] g);
        logic [fifo_aw:0] b;
        b[fifo_aw] = g[fifo_aw];
        for (int i = fifo_aw - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    assign wr_push       = wr_en && !full;
    assign wr_bin_next   = wr_bin + (fifo_aw + 1)'(wr_push);
    assign wr_gray_next  = wr_bin_next ^ (wr_bin_next >> 1);
    assign rd_bin_sync   = gray2bin(rd_gray_sync);
    assign wr_level_next = wr_bin_next - rd_bin_sync;

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_bin[fifo_aw-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge wr_rstn) begin
        if (!wr_rstn) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next;
        end
    end

    // Read pointer into the write domain
    always_ff @(posedge wr_clk or negedge wr_rstn) begin
        if (!wr_rstn) begin
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    // Full when the top two Gray bits differ and the rest match
    always_ff @(posedge wr_clk or negedge wr_rstn) begin
        if (!wr_rstn) begin
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            full        <= (wr_gray_next == {~rd_gray_sync[fifo_aw:fifo_aw-1],
                                              rd_gray_sync[fifo_aw-2:0]});
            almost_full <= (wr_level_next >= (fifo_aw + 1)'(fifo_depth - afull_margin));
        end
    end

    assign rd_pop       = rd_en && !empty;
    assign rd_bin_next  = rd_bin + (fifo_aw + 1)'(rd_pop);
    assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

    always_ff @(posedge rd_clk or negedge rd_rstn) begin
        if (!rd_rstn) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_gray_next;
        end
    end

    // Write pointer into the read domain
    always_ff @(posedge rd_clk or negedge rd_rstn) begin
        if (!rd_rstn) begin
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    always_ff @(posedge rd_clk or negedge rd_rstn) begin
        if (!rd_rstn) begin
            empty <= 1'b1;
        end else begin
            empty <= (rd_gray_next == wr_gray_sync);
        end
    end

    // Head entry is valid while empty is low
    assign rd_data = mem[rd_bin[fifo_aw-1:0]];

endmodule

//--- cdc_channel.sv
module cdc_channel #(
    parameter int width = 8
) (
    input  logic             in_clk,
    input  logic             in_rstn,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [width-1:0] in_data,
    input  logic             out_clk,
    input  logic             out_rstn,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [width-1:0] out_data,
    output logic             idle
);
    import axi_cdc_pkg::*;

    logic             fifo_wr_en;
    logic             fifo_full;
    logic             fifo_afull;
    logic             fifo_rd_en;
    logic [width-1:0] fifo_rd_data;
    logic             fifo_empty;
    logic             out_fire;
    out_state_t       state;

    // Source side
    assign in_ready   = in_rstn && !fifo_afull;
    assign fifo_wr_en = in_valid && in_ready;

    cdc_async_fifo #(
        .width (width)
    ) u_fifo (
        .wr_clk      (in_clk),
        .wr_rstn     (in_rstn),
        .wr_en       (fifo_wr_en),
        .wr_data     (in_data),
        .full        (fifo_full),
        .almost_full (fifo_afull),
        .rd_clk      (out_clk),
        .rd_rstn     (out_rstn),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty)
    );

    // Sink side output register
    assign out_fire   = out_valid && out_ready;
    assign fifo_rd_en = !fifo_empty && ((state == ost_empty) || out_fire);

    always_ff @(posedge out_clk or negedge out_rstn) begin
        if (!out_rstn) begin
            state <= ost_empty;
        end else if (fifo_rd_en) begin
            state <= ost_loaded;
        end else if (out_fire) begin
            state <= ost_empty;
        end
    end

    // Payload held until the sink takes it
    always_ff @(posedge out_clk) begin
        if (fifo_rd_en) begin
            out_data <= fifo_rd_data;
        end
    end

    assign out_valid = (state == ost_loaded);

    // Drained means nothing queued and nothing presented
    assign idle = fifo_empty && (state == ost_empty);

endmodule

//--- master_axi_async.sv
module master_axi_async (
    input  logic                          B_CLK,
    input  logic                          BUS_RSTN_SYNC,
    input  logic                          m_clk,
    input  logic                          master_rstn_sync,

    // Master side
    input  logic [axi_cdc_pkg::id_w-1:0]    m_wr_addr_id,
    input  logic [axi_cdc_pkg::addr_w-1:0]  m_wr_addr,
    input  logic [axi_cdc_pkg::len_w-1:0]   m_wr_addr_len,
    input  logic [axi_cdc_pkg::burst_w-1:0] m_wr_addr_burst,
    input  logic                            m_wr_addr_valid,
    output logic                            m_wr_addr_ready,
    input  logic [axi_cdc_pkg::data_w-1:0]  m_wr_data,
    input  logic [axi_cdc_pkg::strb_w-1:0]  m_wr_strb,
    input  logic                            m_wr_data_last,
    input  logic                            m_wr_data_valid,
    output logic                            m_wr_data_ready,
    output logic [axi_cdc_pkg::id_w-1:0]    m_wr_back_id,
    output logic [axi_cdc_pkg::resp_w-1:0]  m_wr_back_resp,
    output logic                            m_wr_back_valid,
    input  logic                            m_wr_back_ready,
    input  logic [axi_cdc_pkg::id_w-1:0]    m_rd_addr_id,
    input  logic [axi_cdc_pkg::addr_w-1:0]  m_rd_addr,
    input  logic [axi_cdc_pkg::len_w-1:0]   m_rd_addr_len,
    input  logic [axi_cdc_pkg::burst_w-1:0] m_rd_addr_burst,
    input  logic                            m_rd_addr_valid,
    output logic                            m_rd_addr_ready,
    output logic [axi_cdc_pkg::id_w-1:0]    m_rd_back_id,
    output logic [axi_cdc_pkg::data_w-1:0]  m_rd_data,
    output logic [axi_cdc_pkg::resp_w-1:0]  m_rd_data_resp,
    output logic                            m_rd_data_last,
    output logic                            m_rd_data_valid,
    input  logic                            m_rd_data_ready,

    // Bus side
    output logic [axi_cdc_pkg::id_w-1:0]    b_wr_addr_id,
    output logic [axi_cdc_pkg::addr_w-1:0]  b_wr_addr,
    output logic [axi_cdc_pkg::len_w-1:0]   b_wr_addr_len,
    output logic [axi_cdc_pkg::burst_w-1:0] b_wr_addr_burst,
    output logic                            b_wr_addr_valid,
    input  logic                            b_wr_addr_ready,
    output logic [axi_cdc_pkg::data_w-1:0]  b_wr_data,
    output logic [axi_cdc_pkg::strb_w-1:0]  b_wr_strb,
    output logic                            b_wr_data_last,
    output logic                            b_wr_data_valid,
    input  logic                            b_wr_data_ready,
    input  logic [axi_cdc_pkg::id_w-1:0]    b_wr_back_id,
    input  logic [axi_cdc_pkg::resp_w-1:0]  b_wr_back_resp,
    input  logic                            b_wr_back_valid,
    output logic                            b_wr_back_ready,
    output logic [axi_cdc_pkg::id_w-1:0]    b_rd_addr_id,
    output logic [axi_cdc_pkg::addr_w-1:0]  b_rd_addr,
    output logic [axi_cdc_pkg::len_w-1:0]   b_rd_addr_len,
    output logic [axi_cdc_pkg::burst_w-1:0] b_rd_addr_burst,
    output logic                            b_rd_addr_valid,
    input  logic                            b_rd_addr_ready,
    input  logic [axi_cdc_pkg::id_w-1:0]    b_rd_back_id,
    input  logic [axi_cdc_pkg::data_w-1:0]  b_rd_data,
    input  logic [axi_cdc_pkg::resp_w-1:0]  b_rd_data_resp,
    input  logic                            b_rd_data_last,
    input  logic                            b_rd_data_valid,
    output logic                            b_rd_data_ready,

    output logic [4:0]                      fifo_empty_flag
);
    import axi_cdc_pkg::*;

    logic [aw_pkt_w-1:0] wr_addr_in;
    logic [aw_pkt_w-1:0] wr_addr_out;
    logic [aw_pkt_w-1:0] rd_addr_in;
    logic [aw_pkt_w-1:0] rd_addr_out;
    logic [wd_pkt_w-1:0] wr_data_in;
    logic [wd_pkt_w-1:0] wr_data_out;
    logic [rd_pkt_w-1:0] rd_data_in;
    logic [rd_pkt_w-1:0] rd_data_out;
    logic [wb_pkt_w-1:0] wr_back_in;
    logic [wb_pkt_w-1:0] wr_back_out;
    logic                wr_addr_idle;
    logic                rd_addr_idle;
    logic                wr_data_idle;
    logic                rd_data_idle;
    logic                wr_back_idle;

    // Master to bus
    assign wr_addr_in = {m_wr_addr_id, m_wr_addr, m_wr_addr_len, m_wr_addr_burst};
    assign {b_wr_addr_id, b_wr_addr, b_wr_addr_len, b_wr_addr_burst} = wr_addr_out;

    cdc_channel #(.width(aw_pkt_w)) u_wr_addr (
        .in_clk    (m_clk),
        .in_rstn   (master_rstn_sync),
        .in_valid  (m_wr_addr_valid),
        .in_ready  (m_wr_addr_ready),
        .in_data   (wr_addr_in),
        .out_clk   (B_CLK),
        .out_rstn  (BUS_RSTN_SYNC),
        .out_valid (b_wr_addr_valid),
        .out_ready (b_wr_addr_ready),
        .out_data  (wr_addr_out),
        .idle      (wr_addr_idle)
    );

    assign rd_addr_in = {m_rd_addr_id, m_rd_addr, m_rd_addr_len, m_rd_addr_burst};
    assign {b_rd_addr_id, b_rd_addr, b_rd_addr_len, b_rd_addr_burst} = rd_addr_out;

    cdc_channel #(.width(aw_pkt_w)) u_rd_addr (
        .in_clk    (m_clk),
        .in_rstn   (master_rstn_sync),
        .in_valid  (m_rd_addr_valid),
        .in_ready  (m_rd_addr_ready),
        .in_data   (rd_addr_in),
        .out_clk   (B_CLK),
        .out_rstn  (BUS_RSTN_SYNC),
        .out_valid (b_rd_addr_valid),
        .out_ready (b_rd_addr_ready),
        .out_data  (rd_addr_out),
        .idle      (rd_addr_idle)
    );

    assign wr_data_in = {m_wr_data, m_wr_strb, m_wr_data_last};
    assign {b_wr_data, b_wr_strb, b_wr_data_last} = wr_data_out;

    cdc_channel #(.width(wd_pkt_w)) u_wr_data (
        .in_clk    (m_clk),
        .in_rstn   (master_rstn_sync),
        .in_valid  (m_wr_data_valid),
        .in_ready  (m_wr_data_ready),
        .in_data   (wr_data_in),
        .out_clk   (B_CLK),
        .out_rstn  (BUS_RSTN_SYNC),
        .out_valid (b_wr_data_valid),
        .out_ready (b_wr_data_ready),
        .out_data  (wr_data_out),
        .idle      (wr_data_idle)
    );

    // Bus back to master
    assign rd_data_in = {b_rd_back_id, b_rd_data, b_rd_data_resp, b_rd_data_last};
    assign {m_rd_back_id, m_rd_data, m_rd_data_resp, m_rd_data_last} = rd_data_out;

    cdc_channel #(.width(rd_pkt_w)) u_rd_data (
        .in_clk    (B_CLK),
        .in_rstn   (BUS_RSTN_SYNC),
        .in_valid  (b_rd_data_valid),
        .in_ready  (b_rd_data_ready),
        .in_data   (rd_data_in),
        .out_clk   (m_clk),
        .out_rstn  (master_rstn_sync),
        .out_valid (m_rd_data_valid),
        .out_ready (m_rd_data_ready),
        .out_data  (rd_data_out),
        .idle      (rd_data_idle)
    );

    assign wr_back_in = {b_wr_back_id, b_wr_back_resp};
    assign {m_wr_back_id, m_wr_back_resp} = wr_back_out;

    cdc_channel #(.width(wb_pkt_w)) u_wr_back (
        .in_clk    (B_CLK),
        .in_rstn   (BUS_RSTN_SYNC),
        .in_valid  (b_wr_back_valid),
        .in_ready  (b_wr_back_ready),
        .in_data   (wr_back_in),
        .out_clk   (m_clk),
        .out_rstn  (master_rstn_sync),
        .out_valid (m_wr_back_valid),
        .out_ready (m_wr_back_ready),
        .out_data  (wr_back_out),
        .idle      (wr_back_idle)
    );

    // Idle bits MSB first as wr addr, rd addr, wr data, rd data, wr resp
    assign fifo_empty_flag = {wr_addr_idle, rd_addr_idle, wr_data_idle,
                              rd_data_idle, wr_back_idle};

endmodule

//--- tb_master_axi_async_assert.sv
module tb_master_axi_async_assert (
    input logic             clk,
    input logic             rstn,
    input logic [4:0]       valid,
    input logic [4:0]       ready,
    input logic [4:0]       full,
    input logic [4:0][63:0] data
);

    int fail_count = 0;

    for (genvar k = 0; k < 5; k++) begin : g_lane
        hold_a: assert property (@(posedge clk) disable iff (!rstn)
            valid[k] && !ready[k] |=> valid[k] && $stable(data[k]))
            else begin
                $error("Lane %0d dropped valid or changed its payload before ready", k);
                fail_count++;
            end
    end

    // Nothing offered while the domain is held in reset
    reset_a: assert property (@(posedge clk) !rstn |-> valid == 5'b0)
        else begin
            $error("A valid is high while its domain reset is low");
            fail_count++;
        end

    full_a: assert property (@(posedge clk) disable iff (!rstn) (ready & full) == 5'b0)
        else begin
            $error("A source ready is high while its channel FIFO is full");
            fail_count++;
        end

endmodule

// Master clock domain with lanes in fifo_empty_flag order
bind master_axi_async tb_master_axi_async_assert u_master_chk (
    .clk   (m_clk),
    .rstn  (master_rstn_sync),
    .valid ({m_wr_addr_valid, m_rd_addr_valid, m_wr_data_valid, m_rd_data_valid,
             m_wr_back_valid}),
    .ready ({m_wr_addr_ready, m_rd_addr_ready, m_wr_data_ready, m_rd_data_ready,
             m_wr_back_ready}),
    .full  ({u_wr_addr.fifo_full, u_rd_addr.fifo_full, u_wr_data.fifo_full, 2'b00}),
    .data  ({64'(wr_addr_in), 64'(rd_addr_in), 64'(wr_data_in), 64'(rd_data_out),
             64'(wr_back_out)})
);

bind master_axi_async tb_master_axi_async_assert u_bus_chk (
    .clk   (B_CLK),
    .rstn  (BUS_RSTN_SYNC),
    .valid ({b_wr_addr_valid, b_rd_addr_valid, b_wr_data_valid, b_rd_data_valid,
             b_wr_back_valid}),
    .ready ({b_wr_addr_ready, b_rd_addr_ready, b_wr_data_ready, b_rd_data_ready,
             b_wr_back_ready}),
    .full  ({3'b000, u_rd_data.fifo_full, u_wr_back.fifo_full}),
    .data  ({64'(wr_addr_out), 64'(rd_addr_out), 64'(wr_data_out), 64'(rd_data_in),
             64'(wr_back_in)})
);

//--- tb_master_axi_async.sv
module tb_master_axi_async;
    import axi_cdc_pkg::*;

    logic B_CLK = 1'b0;
    logic m_clk = 1'b0;
    logic BUS_RSTN_SYNC;
    logic master_rstn_sync;

    // Master side
    logic [id_w-1:0]    m_wr_addr_id, m_rd_addr_id, m_wr_back_id, m_rd_back_id;
    logic [addr_w-1:0]  m_wr_addr, m_rd_addr;
    logic [len_w-1:0]   m_wr_addr_len, m_rd_addr_len;
    logic [burst_w-1:0] m_wr_addr_burst, m_rd_addr_burst;
    logic [data_w-1:0]  m_wr_data, m_rd_data;
    logic [strb_w-1:0]  m_wr_strb;
    logic [resp_w-1:0]  m_wr_back_resp, m_rd_data_resp;
    logic               m_wr_data_last, m_rd_data_last;
    logic               m_wr_addr_valid, m_rd_addr_valid, m_wr_data_valid;
    logic               m_wr_addr_ready, m_rd_addr_ready, m_wr_data_ready;
    logic               m_wr_back_valid, m_wr_back_ready, m_rd_data_valid, m_rd_data_ready;

    // Bus side
    logic [id_w-1:0]    b_wr_addr_id, b_rd_addr_id, b_wr_back_id, b_rd_back_id;
    logic [addr_w-1:0]  b_wr_addr, b_rd_addr;
    logic [len_w-1:0]   b_wr_addr_len, b_rd_addr_len;
    logic [burst_w-1:0] b_wr_addr_burst, b_rd_addr_burst;
    logic [data_w-1:0]  b_wr_data, b_rd_data;
    logic [strb_w-1:0]  b_wr_strb;
    logic [resp_w-1:0]  b_wr_back_resp, b_rd_data_resp;
    logic               b_wr_data_last, b_rd_data_last;
    logic               b_wr_addr_valid, b_rd_addr_valid, b_wr_data_valid;
    logic               b_wr_addr_ready, b_rd_addr_ready, b_wr_data_ready;
    logic               b_wr_back_valid, b_wr_back_ready, b_rd_data_valid, b_rd_data_ready;
    logic [4:0]         fifo_empty_flag;

    // Payloads still to drive and payloads still to receive
    logic [63:0] aw_src[$], ar_src[$], wd_src[$], rd_src[$], wb_src[$];
    logic [63:0] aw_exp[$], ar_exp[$], wd_exp[$], rd_exp[$], wb_exp[$];

    string       t_name[$];
    string       t_op[$];
    int          t_beats[$];
    logic [31:0] f0[$], f1[$], f2[$], f3[$];

    string  cur_name = "reset";
    int     errors = 0;
    int     cycles = 0;
    int     limit = 0;
    int     wd_accepted = 0;
    logic   stall = 1'b0;
    integer seed = 32'hb2f52eb4;

    always #50 B_CLK = ~B_CLK;
    always #35 m_clk = ~m_clk;

    master_axi_async i_dut (.*);

    task automatic check_beat(input string chan, input int pending, input logic [63:0] exp,
                              input logic [63:0] act);
        assert (pending > 0) else begin
            errors++;
            $display("[ERROR] %s: %s delivered a beat that was never sent", cur_name, chan);
        end
        assert (pending == 0 || exp === act) else begin
            errors++;
            $display("[ERROR] %s: %s expected %h actual %h", cur_name, chan, exp, act);
        end
    endtask

    // Packs the file fields in bus order and queues them on both ends
    task automatic load_beat(input string op, input logic [31:0] a, b, c, d);
        logic [63:0] pkt;
        case (op)
            "op_wr_addr", "op_rd_addr": pkt = 64'({a[1:0], b, c[7:0], d[1:0]});
            "op_wr_data", "op_stall":   pkt = 64'({a, b[3:0], c[0]});
            "op_rd_data":               pkt = 64'({a[1:0], b, c[1:0], d[0]});
            default:                    pkt = 64'({a[1:0], b[1:0]});
        endcase
        case (op)
            "op_wr_addr": begin
                aw_src.push_back(pkt);
                aw_exp.push_back(pkt);
            end
            "op_rd_addr": begin
                ar_src.push_back(pkt);
                ar_exp.push_back(pkt);
            end
            "op_wr_data", "op_stall": begin
                wd_src.push_back(pkt);
                wd_exp.push_back(pkt);
            end
            "op_rd_data": begin
                rd_src.push_back(pkt);
                rd_exp.push_back(pkt);
            end
            "op_wr_back": begin
                wb_src.push_back(pkt);
                wb_exp.push_back(pkt);
            end
            default: begin
                errors++;
                $display("Test %s uses an unknown operation %s", cur_name, op);
            end
        endcase
    endtask

    function automatic int pending_beats();
        return aw_exp.size() + ar_exp.size() + wd_exp.size() + rd_exp.size() + wb_exp.size();
    endfunction

    // Master model and master-side sinks
    always @(posedge m_clk) begin
        logic [31:0] r;
        r = $random(seed);
        if (m_wr_addr_valid && m_wr_addr_ready) void'(aw_src.pop_front());
        if (m_rd_addr_valid && m_rd_addr_ready) void'(ar_src.pop_front());
        if (m_wr_data_valid && m_wr_data_ready) begin
            void'(wd_src.pop_front());
            wd_accepted++;
        end
        m_wr_addr_valid <= aw_src.size() > 0;
        m_rd_addr_valid <= ar_src.size() > 0;
        m_wr_data_valid <= wd_src.size() > 0;
        if (aw_src.size() > 0) begin
            {m_wr_addr_id, m_wr_addr, m_wr_addr_len, m_wr_addr_burst} <= aw_src[0][aw_pkt_w-1:0];
        end
        if (ar_src.size() > 0) begin
            {m_rd_addr_id, m_rd_addr, m_rd_addr_len, m_rd_addr_burst} <= ar_src[0][aw_pkt_w-1:0];
        end
        if (wd_src.size() > 0) begin
            {m_wr_data, m_wr_strb, m_wr_data_last} <= wd_src[0][wd_pkt_w-1:0];
        end
        if (m_wr_back_valid && m_wr_back_ready) begin
            check_beat("m_wr_back", wb_exp.size(), wb_exp.size() ? wb_exp[0] : 64'd0,
                       64'({m_wr_back_id, m_wr_back_resp}));
            if (wb_exp.size() > 0) void'(wb_exp.pop_front());
        end
        if (m_rd_data_valid && m_rd_data_ready) begin
            check_beat("m_rd_data", rd_exp.size(), rd_exp.size() ? rd_exp[0] : 64'd0,
                       64'({m_rd_back_id, m_rd_data, m_rd_data_resp, m_rd_data_last}));
            if (rd_exp.size() > 0) void'(rd_exp.pop_front());
        end
        m_wr_back_ready <= r[0] | r[1];
        m_rd_data_ready <= r[2] | r[3];
    end

    // Bus slave model and bus-side sinks
    always @(posedge B_CLK) begin
        logic [31:0] r;
        r = $random(seed);
        if (b_rd_data_valid && b_rd_data_ready) void'(rd_src.pop_front());
        if (b_wr_back_valid && b_wr_back_ready) void'(wb_src.pop_front());
        b_rd_data_valid <= rd_src.size() > 0;
        b_wr_back_valid <= wb_src.size() > 0;
        if (rd_src.size() > 0) begin
            {b_rd_back_id, b_rd_data, b_rd_data_resp, b_rd_data_last} <= rd_src[0][rd_pkt_w-1:0];
        end
        if (wb_src.size() > 0) begin
            {b_wr_back_id, b_wr_back_resp} <= wb_src[0][wb_pkt_w-1:0];
        end
        if (b_wr_addr_valid && b_wr_addr_ready) begin
            check_beat("b_wr_addr", aw_exp.size(), aw_exp.size() ? aw_exp[0] : 64'd0,
                       64'({b_wr_addr_id, b_wr_addr, b_wr_addr_len, b_wr_addr_burst}));
            if (aw_exp.size() > 0) void'(aw_exp.pop_front());
        end
        if (b_rd_addr_valid && b_rd_addr_ready) begin
            check_beat("b_rd_addr", ar_exp.size(), ar_exp.size() ? ar_exp[0] : 64'd0,
                       64'({b_rd_addr_id, b_rd_addr, b_rd_addr_len, b_rd_addr_burst}));
            if (ar_exp.size() > 0) void'(ar_exp.pop_front());
        end
        if (b_wr_data_valid && b_wr_data_ready) begin
            check_beat("b_wr_data", wd_exp.size(), wd_exp.size() ? wd_exp[0] : 64'd0,
                       64'({b_wr_data, b_wr_strb, b_wr_data_last}));
            if (wd_exp.size() > 0) void'(wd_exp.pop_front());
        end
        b_wr_addr_ready <= r[0] | r[1];
        b_rd_addr_ready <= r[2] | r[3];
        b_wr_data_ready <= !stall && (r[4] | r[5]);
    end

    always @(posedge B_CLK) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d bus clock cycles with beats still in flight", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        int          fd;
        int          n;
        int          i;
        int          k;
        int          remaining;
        int          first;
        int          beats;
        int          ntests;
        int          failed_tests;
        string       line;
        string       nm;
        string       op;
        logic [31:0] a, b, c, d;
        BUS_RSTN_SYNC <= 1'b0;
        master_rstn_sync <= 1'b0;
        {m_wr_addr_id, m_wr_addr, m_wr_addr_len, m_wr_addr_burst, m_wr_addr_valid} <= '0;
        {m_rd_addr_id, m_rd_addr, m_rd_addr_len, m_rd_addr_burst, m_rd_addr_valid} <= '0;
        {m_wr_data, m_wr_strb, m_wr_data_last, m_wr_data_valid} <= '0;
        {b_rd_back_id, b_rd_data, b_rd_data_resp, b_rd_data_last, b_rd_data_valid} <= '0;
        {b_wr_back_id, b_wr_back_resp, b_wr_back_valid} <= '0;
        {m_wr_back_ready, m_rd_data_ready, b_wr_addr_ready, b_rd_addr_ready} <= '0;
        b_wr_data_ready <= 1'b0;
        remaining = 0;
        fd = $fopen("master_axi_async_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the test data file master_axi_async_tests.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;
            if (remaining == 0) begin
                void'($sscanf(line, "%s %s %d", nm, op, n));
                t_name.push_back(nm);
                t_op.push_back(op);
                t_beats.push_back(n);
                remaining = n;
            end else begin
                {a, b, c, d} = '0;
                void'($sscanf(line, "%h %h %h %h", a, b, c, d));
                f0.push_back(a);
                f1.push_back(b);
                f2.push_back(c);
                f3.push_back(d);
                remaining--;
            end
        end
        limit = f0.size() * 40 + 500;

        repeat (16) @(posedge B_CLK);
        BUS_RSTN_SYNC <= 1'b1;
        @(posedge m_clk);
        master_rstn_sync <= 1'b1;
        @(negedge B_CLK);
        assert (fifo_empty_flag == 5'h1f) else begin
            errors++;
            $display("[ERROR] reset: fifo_empty_flag expected 1f actual %h", fifo_empty_flag);
        end

        // Records that share a name run together as one test
        i = 0;
        k = 0;
        ntests = 0;
        failed_tests = 0;
        while (i < t_name.size()) begin
            @(negedge B_CLK);
            cur_name = t_name[i];
            first = errors;
            beats = 0;
            wd_accepted = 0;
            while (i < t_name.size() && t_name[i] == cur_name) begin
                if (t_op[i] == "op_stall") stall = 1'b1;
                for (int j = 0; j < t_beats[i] && k < f0.size(); j++) begin
                    load_beat(t_op[i], f0[k], f1[k], f2[k], f3[k]);
                    k++;
                end
                beats += t_beats[i];
                i++;
            end
            if (stall) begin
                // Wait for back-pressure to reach the master side and hold it a while
                @(posedge m_clk);
                while (m_wr_data_ready || !m_wr_data_valid) @(posedge m_clk);
                repeat (20) @(posedge m_clk);
                assert (wd_accepted < fifo_depth) else begin
                    errors++;
                    $display("[ERROR] %s: accepted beats expected below %0d actual %0d",
                             cur_name, fifo_depth, wd_accepted);
                end
                assert (fifo_empty_flag[2] == 1'b0) else begin
                    errors++;
                    $display("[ERROR] %s: write data idle bit expected 0 actual 1", cur_name);
                end
                stall = 1'b0;
            end
            while (pending_beats() > 0) @(negedge B_CLK);
            // Idle flag trails the last pop by the synchronizers
            n = 0;
            while (fifo_empty_flag != 5'h1f && n < 10) begin
                @(negedge B_CLK);
                n++;
            end
            assert (fifo_empty_flag == 5'h1f) else begin
                errors++;
                $display("[ERROR] %s: fifo_empty_flag expected 1f actual %h",
                         cur_name, fifo_empty_flag);
            end
            ntests++;
            if (errors > first) failed_tests++;
            $display("Test %s: %0d beats, %0d errors", cur_name, beats, errors - first);
        end

        errors += i_dut.u_master_chk.fail_count + i_dut.u_bus_chk.fail_count;
        $display("%0d tests run, %0d with errors, %0d failed checks",
                 ntests, failed_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- master_axi_async.f
axi_cdc_pkg.sv
cdc_async_fifo.sv
cdc_channel.sv
master_axi_async.sv
tb_master_axi_async_assert.sv
tb_master_axi_async.sv

//--- master_axi_async_tests.txt
# Header line: name op beats, then one hex line per beat
# addr: id addr len burst | data, stall: data strb last | rd_data: id data resp last | wr_back: id resp
wr_addr_order op_wr_addr 2
1 80001000 07 1
2 80002040 00 0
rd_addr_order op_rd_addr 2
3 40000100 0f 2
0 40000200 03 1
wr_data_burst op_wr_data 8
11111111 f 0
22222222 3 0
33333333 c 0
44444444 f 1
55555555 1 0
66666666 2 0
77777777 4 0
88888888 8 1
wr_back_order op_wr_back 2
1 0
2 2
rd_data_order op_rd_data 2
3 deadbeef 0 0
3 cafef00d 1 1
wd_backpressure op_stall 20
a0000000 f 0
a0000001 1 0
a0000002 2 0
a0000003 4 1
a0000004 8 0
a0000005 3 0
a0000006 c 0
a0000007 f 1
a0000008 5 0
a0000009 a 0
a000000a 6 0
a000000b 9 1
a000000c f 0
a000000d e 0
a000000e d 0
a000000f b 1
a0000010 7 0
a0000011 f 0
a0000012 0 0
a0000013 f 1
mixed_random op_wr_addr 2
2 90000000 01 1
3 90000080 ff 2
mixed_random op_rd_data 2
1 0badf00d 2 0
1 12345678 3 1
mixed_random op_wr_back 2
3 1
0 3
